// ==== verilog/txs_rd_pkg.sv ====
`default_nettype none

package txs_rd_pkg;

  localparam int AVL_ADDR_W      = 20;
  localparam int BYTES_PER_BEAT  = 16;   // one avalon beat is a 128-bit word
  localparam int PAGE_BYTES      = 4096; // pcie requests may not cross this
  localparam int MAX_PEND_RD     = 8;
  localparam int CMD_FIFO_OK_LVL = 8;
  localparam int PEND_FIFO_DEPTH = 16;

  typedef logic [AVL_ADDR_W-1:0] avl_addr_t;
  typedef logic [5:0]            burst_cnt_t;
  typedef logic [12:0]           byte_cnt_t;
  typedef logic [8:0]            dw_len_t;
  typedef logic [3:0]            tag_t;
  typedef logic [63:0]           pcie_addr_t;

  typedef struct packed {
    avl_addr_t addr;   // word aligned start
    byte_cnt_t bytes;  // whole read
  } avl_rd_req_t;

  typedef struct packed {
    pcie_addr_t addr;
    logic       space64;
  } pcie_xlat_t;

  typedef struct packed {
    logic       last_seg;
    dw_len_t    dw_len;
    tag_t       tag;
    logic       is_64;
    pcie_addr_t addr;
  } tx_rd_hdr_t;

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT_ADDR, RD_HEADER, RD_PIPE} rd_state_e;

  typedef enum logic [1:0] {PND_IDLE, PND_LATCH, PND_CHECK} pnd_state_e;

endpackage

`default_nettype wire

// ==== verilog/txs_rd_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module txs_rd_capture
(
  input  wire                          AvlClk_i,
  input  wire                          Rstn_i,
  input  wire txs_rd_pkg::avl_addr_t   TxAddress_i,
  input  wire txs_rd_pkg::burst_cnt_t  TxBurstCount_i,
  input  wire                          rd_accept_i,
  input  wire                          AddrTransDone_i,
  input  wire txs_rd_pkg::pcie_addr_t  PCIeAddr_i,
  input  wire [1:0]                    PCIeAddrSpace_i,
  output txs_rd_pkg::avl_rd_req_t      rd_req_o,
  output txs_rd_pkg::pcie_xlat_t       xlat_o,
  output logic                         xlat_rise_o
);

  logic done_q;  // previous AddrTransDone_i

  // read request, held for the whole split
  always_ff @(posedge AvlClk_i)
  begin
    if (rd_accept_i)
    begin
      rd_req_o.addr  <= TxAddress_i &
                        ~txs_rd_pkg::avl_addr_t'(txs_rd_pkg::BYTES_PER_BEAT - 1);
      rd_req_o.bytes <= txs_rd_pkg::byte_cnt_t'(TxBurstCount_i) *
                        txs_rd_pkg::byte_cnt_t'(txs_rd_pkg::BYTES_PER_BEAT);
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      done_q <= 1'b0;
    else
      done_q <= AddrTransDone_i;
  end

  assign xlat_rise_o = AddrTransDone_i & ~done_q;

  // translator result is only valid on the first cycle of done
  always_ff @(posedge AvlClk_i)
  begin
    if (xlat_rise_o)
    begin
      xlat_o.addr    <= PCIeAddr_i;
      xlat_o.space64 <= PCIeAddrSpace_i[0];  // bit 1 carries no meaning for reads
    end
  end

endmodule

`default_nettype wire

// ==== verilog/txs_rd_split_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module txs_rd_split_fsm
(
  input  wire                           AvlClk_i,
  input  wire                           Rstn_i,
  input  wire                           TxChipSelect_i,
  input  wire                           TxRead_i,
  input  wire                           MasterEnable_i,
  input  wire                           AddrTransDone_i,
  input  wire [3:0]                     CmdFifoUsedW_i,
  input  wire [31:0]                    DevCsr_i,
  input  wire                           rd_credit_ok_i,
  input  wire txs_rd_pkg::avl_rd_req_t  rd_req_i,
  output logic                          TxWaitRequest_o,
  output logic                          rd_accept_o,
  output logic                          AvlAddrVld_o,
  output txs_rd_pkg::avl_addr_t         AvlAddr_o,
  output logic                          hdr_strobe_o,
  output logic                          seg_last_o,
  output txs_rd_pkg::byte_cnt_t         seg_bytes_o
);

  txs_rd_pkg::rd_state_e state_q;
  txs_rd_pkg::rd_state_e state_d;
  txs_rd_pkg::byte_cnt_t done_bytes_q;  // bytes already issued for this read
  txs_rd_pkg::avl_addr_t seg_addr;
  txs_rd_pkg::byte_cnt_t remain_bytes;
  txs_rd_pkg::byte_cnt_t bytes_to_4k;
  txs_rd_pkg::byte_cnt_t max_rd_size;
  logic                  wait_q;        // second or later cycle of WAIT_ADDR
  logic                  sel_remain;
  logic                  sel_4k;
  logic                  sel_remain_q;
  logic                  sel_4k_q;
  logic                  cmd_fifo_ok;

  assign cmd_fifo_ok = (CmdFifoUsedW_i <= txs_rd_pkg::CMD_FIFO_OK_LVL);

  assign rd_accept_o = (state_q == txs_rd_pkg::RD_IDLE) & TxChipSelect_i & TxRead_i &
                       rd_credit_ok_i & MasterEnable_i & ~AddrTransDone_i;
  assign TxWaitRequest_o = ~rd_accept_o;

  assign seg_addr     = rd_req_i.addr + txs_rd_pkg::avl_addr_t'(done_bytes_q);
  assign remain_bytes = rd_req_i.bytes - done_bytes_q;
  assign bytes_to_4k  = txs_rd_pkg::byte_cnt_t'(txs_rd_pkg::PAGE_BYTES) -
                        txs_rd_pkg::byte_cnt_t'(seg_addr[$clog2(txs_rd_pkg::PAGE_BYTES)-1:0]);

  always_comb
  begin
    case (DevCsr_i[14:12])  // max read request size field
      3'b000:  max_rd_size = 13'd128;
      3'b001:  max_rd_size = 13'd256;
      default: max_rd_size = 13'd512;
    endcase
  end

  assign sel_remain = (remain_bytes <= max_rd_size) & (remain_bytes <= bytes_to_4k);
  assign sel_4k     = ~sel_remain & (bytes_to_4k <= max_rd_size);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      txs_rd_pkg::RD_IDLE:
        if (rd_accept_o)
          state_d = txs_rd_pkg::RD_WAIT_ADDR;
      txs_rd_pkg::RD_WAIT_ADDR:
        if (wait_q & AddrTransDone_i & cmd_fifo_ok)
          state_d = txs_rd_pkg::RD_HEADER;
      txs_rd_pkg::RD_HEADER:
        state_d = seg_last_o ? txs_rd_pkg::RD_IDLE : txs_rd_pkg::RD_PIPE;
      txs_rd_pkg::RD_PIPE:
        if (!AddrTransDone_i)  // translator has seen valid drop
          state_d = txs_rd_pkg::RD_WAIT_ADDR;
      default:
        state_d = txs_rd_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q      <= txs_rd_pkg::RD_IDLE;
      wait_q       <= 1'b0;
      done_bytes_q <= '0;
      sel_remain_q <= 1'b0;
      sel_4k_q     <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      wait_q       <= (state_q == txs_rd_pkg::RD_WAIT_ADDR);
      sel_remain_q <= sel_remain;  // size select pipelined for fmax
      sel_4k_q     <= sel_4k;
      if (rd_accept_o)
        done_bytes_q <= '0;
      else if (hdr_strobe_o)
        done_bytes_q <= done_bytes_q + seg_bytes_o;
    end
  end

  assign seg_bytes_o  = sel_remain_q ? remain_bytes : (sel_4k_q ? bytes_to_4k : max_rd_size);
  assign seg_last_o   = sel_remain_q;
  assign hdr_strobe_o = (state_q == txs_rd_pkg::RD_HEADER);
  assign AvlAddrVld_o = (state_q == txs_rd_pkg::RD_WAIT_ADDR);
  assign AvlAddr_o    = seg_addr;

endmodule

`default_nettype wire

// ==== verilog/pending_rd_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pending_rd_tracker
(
  input  wire                          AvlClk_i,
  input  wire                          Rstn_i,
  input  wire                          rd_accept_i,
  input  wire txs_rd_pkg::burst_cnt_t  TxBurstCount_i,
  input  wire                          TxsReadDataValid_i,
  output logic                         rd_credit_ok_o
);

  txs_rd_pkg::burst_cnt_t mem_q [txs_rd_pkg::PEND_FIFO_DEPTH];
  logic [$clog2(txs_rd_pkg::PEND_FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(txs_rd_pkg::PEND_FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(txs_rd_pkg::PEND_FIFO_DEPTH):0]   fill_q;
  txs_rd_pkg::burst_cnt_t fifo_q;   // registered queue output
  txs_rd_pkg::burst_cnt_t head_q;   // burst count of the oldest read
  txs_rd_pkg::pnd_state_e state_q;
  txs_rd_pkg::pnd_state_e state_d;
  logic [9:0]             beat_cnt_q;
  logic [3:0]             pend_cnt_q;
  logic                   empty;
  logic                   pop;
  logic                   retire;

  assign empty  = (fill_q == '0);
  // single-cycle pulse, CHECK is always left on a match
  assign retire = (state_q == txs_rd_pkg::PND_CHECK) & (beat_cnt_q >= 10'(head_q));
  assign pop    = ~empty & ((state_q == txs_rd_pkg::PND_IDLE) | retire);

  always_ff @(posedge AvlClk_i)
  begin
    if (rd_accept_i)
      mem_q[wr_ptr_q] <= TxBurstCount_i;
    if (pop)
      fifo_q <= mem_q[rd_ptr_q];
    if (state_q == txs_rd_pkg::PND_LATCH)
      head_q <= fifo_q;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      txs_rd_pkg::PND_IDLE:  if (!empty) state_d = txs_rd_pkg::PND_LATCH;
      txs_rd_pkg::PND_LATCH: state_d = txs_rd_pkg::PND_CHECK;
      txs_rd_pkg::PND_CHECK:
        if (retire)
          state_d = empty ? txs_rd_pkg::PND_IDLE : txs_rd_pkg::PND_LATCH;
      default: state_d = txs_rd_pkg::PND_IDLE;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q    <= txs_rd_pkg::PND_IDLE;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      beat_cnt_q <= '0;
      pend_cnt_q <= '0;
    end
    else
    begin
      state_q  <= state_d;
      wr_ptr_q <= wr_ptr_q + rd_accept_i;
      rd_ptr_q <= rd_ptr_q + pop;
      if (rd_accept_i & ~pop)
        fill_q <= fill_q + 1'b1;
      else if (pop & ~rd_accept_i)
        fill_q <= fill_q - 1'b1;
      // beats beyond the head entry carry over to the next read
      beat_cnt_q <= beat_cnt_q - (retire ? 10'(head_q) : 10'd0) + 10'(TxsReadDataValid_i);
      if (rd_accept_i & ~retire)
        pend_cnt_q <= pend_cnt_q + 1'b1;
      else if (~rd_accept_i & retire)
        pend_cnt_q <= pend_cnt_q - 1'b1;
    end
  end

  assign rd_credit_ok_o = (pend_cnt_q < txs_rd_pkg::MAX_PEND_RD);

endmodule

`default_nettype wire

// ==== verilog/tx_req_header_fmt.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_req_header_fmt
(
  input  wire                         AvlClk_i,
  input  wire                         Rstn_i,
  input  wire                         hdr_strobe_i,
  input  wire                         seg_last_i,
  input  wire txs_rd_pkg::byte_cnt_t  seg_bytes_i,
  input  wire txs_rd_pkg::pcie_xlat_t xlat_i,
  output logic                        CmdFifoWrReq_o,
  output txs_rd_pkg::tx_rd_hdr_t      TxReqHeader_o
);

  txs_rd_pkg::tag_t tag_q;

  // one tag per header, wraps at 16
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      tag_q <= '0;
    else if (hdr_strobe_i)
      tag_q <= tag_q + 1'b1;
  end

  assign CmdFifoWrReq_o = hdr_strobe_i;

  always_comb
  begin
    TxReqHeader_o.last_seg = seg_last_i;
    TxReqHeader_o.dw_len   = txs_rd_pkg::dw_len_t'(seg_bytes_i >> 2);  // bytes to dwords
    TxReqHeader_o.tag      = tag_q;
    // 4DW header only when the upper half is really used
    TxReqHeader_o.is_64    = xlat_i.space64 & (|xlat_i.addr[63:32]);
    TxReqHeader_o.addr     = xlat_i.addr;
  end

endmodule

`default_nettype wire

// ==== verilog/txs_rd_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module txs_rd_ctrl_top
(
  input  wire                          AvlClk_i,
  input  wire                          Rstn_i,
  input  wire                          TxChipSelect_i,
  input  wire                          TxRead_i,
  input  wire txs_rd_pkg::burst_cnt_t  TxBurstCount_i,
  input  wire txs_rd_pkg::avl_addr_t   TxAddress_i,
  output logic                         TxWaitRequest_o,
  output logic                         AvlAddrVld_o,
  output txs_rd_pkg::avl_addr_t        AvlAddr_o,
  input  wire                          AddrTransDone_i,
  input  wire txs_rd_pkg::pcie_addr_t  PCIeAddr_i,
  input  wire [1:0]                    PCIeAddrSpace_i,
  output logic                         CmdFifoWrReq_o,
  output txs_rd_pkg::tx_rd_hdr_t       TxReqHeader_o,
  input  wire [3:0]                    CmdFifoUsedW_i,
  input  wire [31:0]                   DevCsr_i,
  input  wire                          MasterEnable_i,
  input  wire                          TxsReadDataValid_i
);

  logic                    rd_accept;
  logic                    rd_credit_ok;
  txs_rd_pkg::avl_rd_req_t rd_req;
  txs_rd_pkg::pcie_xlat_t  xlat;
  logic                    hdr_strobe;
  logic                    seg_last;
  txs_rd_pkg::byte_cnt_t   seg_bytes;

  txs_rd_capture u_capture (
    .AvlClk_i(AvlClk_i), .Rstn_i(Rstn_i), .TxAddress_i(TxAddress_i),
    .TxBurstCount_i(TxBurstCount_i), .rd_accept_i(rd_accept),
    .AddrTransDone_i(AddrTransDone_i), .PCIeAddr_i(PCIeAddr_i),
    .PCIeAddrSpace_i(PCIeAddrSpace_i), .rd_req_o(rd_req), .xlat_o(xlat),
    .xlat_rise_o()
  );

  txs_rd_split_fsm u_split (
    .AvlClk_i(AvlClk_i), .Rstn_i(Rstn_i), .TxChipSelect_i(TxChipSelect_i),
    .TxRead_i(TxRead_i), .MasterEnable_i(MasterEnable_i),
    .AddrTransDone_i(AddrTransDone_i), .CmdFifoUsedW_i(CmdFifoUsedW_i),
    .DevCsr_i(DevCsr_i), .rd_credit_ok_i(rd_credit_ok), .rd_req_i(rd_req),
    .TxWaitRequest_o(TxWaitRequest_o), .rd_accept_o(rd_accept),
    .AvlAddrVld_o(AvlAddrVld_o), .AvlAddr_o(AvlAddr_o), .hdr_strobe_o(hdr_strobe),
    .seg_last_o(seg_last), .seg_bytes_o(seg_bytes)
  );

  pending_rd_tracker u_pend (
    .AvlClk_i(AvlClk_i), .Rstn_i(Rstn_i), .rd_accept_i(rd_accept),
    .TxBurstCount_i(TxBurstCount_i), .TxsReadDataValid_i(TxsReadDataValid_i),
    .rd_credit_ok_o(rd_credit_ok)
  );

  tx_req_header_fmt u_hdr (
    .AvlClk_i(AvlClk_i), .Rstn_i(Rstn_i), .hdr_strobe_i(hdr_strobe),
    .seg_last_i(seg_last), .seg_bytes_i(seg_bytes), .xlat_i(xlat),
    .CmdFifoWrReq_o(CmdFifoWrReq_o), .TxReqHeader_o(TxReqHeader_o)
  );

endmodule

`default_nettype wire

// ==== test/txs_rd_ctrl_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module txs_rd_ctrl_props
(
  input wire AvlClk_i,
  input wire Rstn_i,
  input wire TxChipSelect_i,
  input wire TxWaitRequest_o,
  input wire AvlAddrVld_o,
  input wire CmdFifoWrReq_o
);

  // one strobe per HEADER state
  a_single_wr: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    CmdFifoWrReq_o |=> !CmdFifoWrReq_o)
    else $error("command FIFO write strobe high in two consecutive cycles");

  a_no_vld_on_wr: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    CmdFifoWrReq_o |-> !AvlAddrVld_o)
    else $error("address valid high while a header is written");

  a_wait_no_cs: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    !TxChipSelect_i |-> TxWaitRequest_o)
    else $error("wait request low without chip select");

endmodule

bind txs_rd_ctrl_top txs_rd_ctrl_props u_props
(
  .AvlClk_i(AvlClk_i),
  .Rstn_i(Rstn_i),
  .TxChipSelect_i(TxChipSelect_i),
  .TxWaitRequest_o(TxWaitRequest_o),
  .AvlAddrVld_o(AvlAddrVld_o),
  .CmdFifoWrReq_o(CmdFifoWrReq_o)
);

`default_nettype wire

// ==== test/tb_txs_rd_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_txs_rd_ctrl;

  logic                   avl_clk = 1'b0;
  logic                   rstn;
  logic                   tx_cs;
  logic                   tx_rd;
  txs_rd_pkg::burst_cnt_t tx_burst;
  txs_rd_pkg::avl_addr_t  tx_addr;
  logic                   addr_done = 1'b0;
  txs_rd_pkg::pcie_addr_t pcie_addr = '0;
  logic [1:0]             pcie_space;
  logic [3:0]             fifo_lvl = '0;
  logic [31:0]            dev_csr;
  logic                   master_en;
  logic                   beat_vld = 1'b0;
  logic                   wait_req;
  logic                   addr_vld;
  txs_rd_pkg::avl_addr_t  avl_addr;
  logic                   cmd_wr;
  txs_rd_pkg::tx_rd_hdr_t hdr;

  txs_rd_pkg::tx_rd_hdr_t exp_q[$];  // predicted headers, oldest first
  txs_rd_pkg::tx_rd_hdr_t want;
  txs_rd_pkg::tag_t       exp_tag = '0;
  txs_rd_pkg::pcie_addr_t win_base = '0;  // translation window
  logic                   space_bit = 1'b0;
  int unsigned            max_rd = 128;
  logic                   vld_smp = 1'b0;
  txs_rd_pkg::avl_addr_t  addr_smp = '0;
  int                     xl_wait = 0;
  int                     beats_issued = 0;
  int                     beats_returned = 0;
  logic                   hold_cpl = 1'b0;
  logic                   fifo_full = 1'b0;
  int                     reads_issued = 0;
  int                     cycles = 0;
  int                     hdr_checks = 0;
  int                     hdr_errors = 0;
  int                     test_checks = 0;
  int                     test_errors = 0;
  int                     err_mark;
  int                     acc_cnt;
  int unsigned            k;
  bit                     acc;

  always #2 avl_clk = ~avl_clk;

  txs_rd_ctrl_top u_dut
  (
    .AvlClk_i(avl_clk),
    .Rstn_i(rstn),
    .TxChipSelect_i(tx_cs),
    .TxRead_i(tx_rd),
    .TxBurstCount_i(tx_burst),
    .TxAddress_i(tx_addr),
    .TxWaitRequest_o(wait_req),
    .AvlAddrVld_o(addr_vld),
    .AvlAddr_o(avl_addr),
    .AddrTransDone_i(addr_done),
    .PCIeAddr_i(pcie_addr),
    .PCIeAddrSpace_i(pcie_space),
    .CmdFifoWrReq_o(cmd_wr),
    .TxReqHeader_o(hdr),
    .CmdFifoUsedW_i(fifo_lvl),
    .DevCsr_i(dev_csr),
    .MasterEnable_i(master_en),
    .TxsReadDataValid_i(beat_vld)
  );

  always @(negedge avl_clk)
  begin
    vld_smp  <= addr_vld;
    addr_smp <= avl_addr;
  end

  // translator answers after 1 to 4 cycles and holds done until valid drops
  always @(posedge avl_clk)
  begin
    if (addr_done)
    begin
      if (!vld_smp)
        addr_done <= 1'b0;
    end
    else if (vld_smp)
    begin
      if (xl_wait == 0)
      begin
        addr_done <= 1'b1;
        pcie_addr <= win_base + txs_rd_pkg::pcie_addr_t'(addr_smp);
      end
      else
        xl_wait <= xl_wait - 1;
    end
    else
      xl_wait <= $urandom_range(0, 3);
  end

  // read data returns one beat at a time with random gaps
  always @(posedge avl_clk)
  begin
    if (rstn && !hold_cpl && beats_returned < beats_issued && $urandom_range(0, 1) == 0)
    begin
      beat_vld       <= 1'b1;
      beats_returned <= beats_returned + 1;
    end
    else
      beat_vld <= 1'b0;
  end

  always @(posedge avl_clk)
    fifo_lvl <= fifo_full ? 4'd12 : 4'($urandom_range(0, 10));

  // header checker against the predicted list
  always @(negedge avl_clk)
  begin
    if (rstn && cmd_wr)
    begin
      hdr_checks++;
      assert (exp_q.size() != 0) else
      begin
        $display("header written at %0t while no segment was expected", $time);
        hdr_errors++;
      end
      if (exp_q.size() != 0)
      begin
        want     = exp_q.pop_front();
        want.tag = exp_tag;
        assert (hdr == want) else
        begin
          $display("[FAIL] %0t header got %h expected %h", $time, hdr, want);
          hdr_errors++;
        end
        exp_tag = exp_tag + 1'b1;
      end
    end
  end

  always @(posedge avl_clk)
  begin
    cycles <= cycles + 1;
    if (cycles > 200 * reads_issued + 1000)
    begin
      $display("timeout after %0d cycles, a read or a header never completed", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic int unsigned rand_page();
    return $urandom_range(0, 250) * 4096;
  endfunction

  task automatic set_max_rd(input int unsigned field);
    begin
      dev_csr <= {17'd0, 3'(field), 12'd0};  // bits 14:12
      max_rd = (field == 0) ? 128 : ((field == 1) ? 256 : 512);
    end
  endtask

  // split a read by remaining bytes, max read size and 4 KB pages
  task automatic predict_read(input int unsigned addr, input int unsigned bytes);
    int unsigned cur;
    int unsigned left;
    int unsigned seg;
    txs_rd_pkg::tx_rd_hdr_t h;
    begin
      cur  = addr & ~32'hf;
      left = bytes;
      while (left != 0)
      begin
        seg = left;
        if (seg > max_rd)
          seg = max_rd;
        if (seg > 4096 - cur % 4096)
          seg = 4096 - cur % 4096;
        h.last_seg = (seg == left);
        h.dw_len   = txs_rd_pkg::dw_len_t'(seg / 4);
        h.tag      = '0;  // set by the checker
        h.is_64    = space_bit & (win_base[63:32] != 32'd0);
        h.addr     = win_base + 64'(cur);
        exp_q.push_back(h);
        cur  = cur + seg;
        left = left - seg;
      end
    end
  endtask

  task automatic issue_read(input int unsigned addr, input int unsigned burst,
                            input int limit, output bit accepted);
    int n;
    begin
      accepted = 1'b0;
      n        = 0;
      reads_issued++;
      @(posedge avl_clk);
      tx_addr  <= txs_rd_pkg::avl_addr_t'(addr);
      tx_burst <= txs_rd_pkg::burst_cnt_t'(burst);
      tx_cs    <= 1'b1;
      tx_rd    <= 1'b1;
      while (!accepted && n < limit)
      begin
        @(negedge avl_clk);
        accepted = !wait_req;  // taken at the next rising edge
        n++;
      end
      if (accepted)
      begin
        predict_read(addr, burst * 16);
        beats_issued += int'(burst);
      end
      @(posedge avl_clk);
      tx_cs <= 1'b0;
      tx_rd <= 1'b0;
    end
  endtask

  task automatic wait_headers();
    begin
      while (exp_q.size() != 0)
        @(posedge avl_clk);
    end
  endtask

  task automatic run_read(input int unsigned addr, input int unsigned burst);
    bit ok;
    begin
      issue_read(addr, burst, 1000, ok);
      test_checks++;
      assert (ok) else
      begin
        $display("[FAIL] %0t read at %h was never accepted", $time, addr);
        test_errors++;
      end
      wait_headers();
    end
  endtask

  task automatic end_test(input string name, input int mark);
    begin
      $display("test %s: %s", name, (test_errors + hdr_errors == mark) ? "ok" : "errors found");
    end
  endtask

  initial
  begin
    void'($urandom(48));
    rstn       = 1'b0;
    tx_cs      = 1'b0;
    tx_rd      = 1'b0;
    tx_burst   = '0;
    tx_addr    = '0;
    pcie_space = 2'b00;
    dev_csr    = '0;
    master_en  = 1'b1;
    repeat (8) @(posedge avl_clk);
    rstn <= 1'b1;
    repeat (4) @(posedge avl_clk);

    err_mark = test_errors + hdr_errors;
    win_base = 64'h0000_0000_4000_0000;
    for (int i = 0; i < 8; i++)
    begin
      set_max_rd($urandom_range(0, 2));
      run_read(rand_page() + 16 * $urandom_range(0, 200), $urandom_range(1, 8));
    end
    end_test("single segment", err_mark);

    err_mark   = test_errors + hdr_errors;
    win_base   = 64'h0000_0012_8000_0000;
    space_bit  = 1'b1;
    pcie_space <= 2'b01;
    for (int i = 0; i < 12; i++)
    begin
      set_max_rd($urandom_range(0, 2));
      // low address bits must be ignored by the DUT
      run_read(rand_page() + 16 * $urandom_range(0, 190) + $urandom_range(0, 15),
               $urandom_range(9, 63));
    end
    end_test("max read size split", err_mark);

    err_mark = test_errors + hdr_errors;
    win_base = 64'h0000_0000_2000_0000;
    for (int i = 0; i < 12; i++)
    begin
      set_max_rd($urandom_range(0, 2));
      k = $urandom_range(1, 16);
      run_read(rand_page() + 4096 - 16 * k, $urandom_range(k + 1, 63));
    end
    end_test("4 KB boundary split", err_mark);

    err_mark = test_errors + hdr_errors;
    while (beats_returned != beats_issued)
      @(posedge avl_clk);
    repeat (40) @(posedge avl_clk);  // let the tracker retire everything
    hold_cpl = 1'b1;
    acc_cnt  = 0;
    for (int i = 0; i < 10; i++)
    begin
      issue_read(rand_page(), $urandom_range(1, 4), 40, acc);
      if (acc)
        acc_cnt++;
      wait_headers();
    end
    test_checks++;
    assert (acc_cnt == txs_rd_pkg::MAX_PEND_RD) else
    begin
      $display("[FAIL] %0t %0d reads accepted with no data returned", $time, acc_cnt);
      test_errors++;
    end
    hold_cpl = 1'b0;
    issue_read(rand_page(), $urandom_range(1, 4), 1000, acc);
    test_checks++;
    assert (acc) else
    begin
      $display("[FAIL] %0t read refused after data returned", $time);
      test_errors++;
    end
    wait_headers();
    end_test("pending read limit", err_mark);

    err_mark  = test_errors + hdr_errors;
    fifo_full = 1'b1;
    repeat (2) @(posedge avl_clk);
    issue_read(rand_page(), $urandom_range(1, 8), 1000, acc);
    repeat (40)
    begin
      @(negedge avl_clk);
      test_checks++;
      assert (acc && !cmd_wr) else
      begin
        $display("[FAIL] %0t header written or read refused while FIFO full", $time);
        test_errors++;
      end
    end
    fifo_full = 1'b0;
    wait_headers();
    end_test("command FIFO back-pressure", err_mark);

    err_mark = test_errors + hdr_errors;
    for (int c = 0; c < 4; c++)
    begin
      space_bit  = c[0];
      win_base   = c[1] ? 64'h0000_00a5_0000_0000 : 64'h0000_0000_9000_0000;
      pcie_space <= {1'($urandom_range(0, 1)), c[0]};  // bit 1 has no meaning
      repeat (2)
      begin
        set_max_rd($urandom_range(0, 2));
        run_read(rand_page() + 16 * $urandom_range(0, 190), $urandom_range(1, 63));
      end
    end
    end_test("64-bit header select", err_mark);

    repeat (20) @(posedge avl_clk);
    $display("%0d checks, %0d errors", hdr_checks + test_checks, hdr_errors + test_errors);
    if (hdr_errors + test_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/txs_rd_pkg.sv
verilog/txs_rd_capture.sv
verilog/txs_rd_split_fsm.sv
verilog/pending_rd_tracker.sv
verilog/tx_req_header_fmt.sv
verilog/txs_rd_ctrl_top.sv
test/txs_rd_ctrl_props.sv
test/tb_txs_rd_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the Avalon read command controller testbench

VERILATOR ?= verilator
TOP       ?= tb_txs_rd_ctrl
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
